// ==== Makefile ====
# Verilator build for the teaching processor board

VERILATOR ?= verilator
TOP       ?= tb_mother_board
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== common/cpu_pkg.sv ====
package cpu_pkg;

    // ------------------------------------------------------------------------
    // datapath sizes
    // ------------------------------------------------------------------------
    localparam int xlen       = 32;
    localparam int reg_count  = 16;
    localparam int reg_idx_w  = 4;
    localparam int apb_addr_w = 12;

    // instruction fields, lsb position and width
    localparam int imm_lsb    = 20;                   // imm is signed, 12 bits
    localparam int imm_w      = 12;
    localparam int rs2_lsb    = 16;
    localparam int rs1_lsb    = 12;
    localparam int rd_lsb     = 8;
    localparam int opt_lsb    = 4;
    localparam int opt_w      = 4;
    localparam int opcode_lsb = 0;
    localparam int opcode_w   = 4;

    // opcodes, anything else is a nop
    localparam logic [3:0] op_addi = 4'h0;
    localparam logic [3:0] op_jalr = 4'h2;
    localparam logic [3:0] op_jcc  = 4'h3;
    localparam logic [3:0] op_halt = 4'hA;

    // jump conditions on x[rs2] vs zero, 6..15 never taken
    localparam logic [3:0] cond_eq = 4'd0;
    localparam logic [3:0] cond_ne = 4'd1;
    localparam logic [3:0] cond_ge = 4'd2;
    localparam logic [3:0] cond_lt = 4'd3;
    localparam logic [3:0] cond_gt = 4'd4;
    localparam logic [3:0] cond_le = 4'd5;

    // ------------------------------------------------------------------------
    // apb address map (byte addresses)
    // ------------------------------------------------------------------------
    localparam logic [apb_addr_w-1:0] addr_ctrl     = 12'h000; // bit 0 = start
    localparam logic [apb_addr_w-1:0] addr_status   = 12'h004; // pc, halted, busy
    localparam logic [apb_addr_w-1:0] addr_reg_base = 12'h040; // x0..x15, read only
    localparam logic [apb_addr_w-1:0] addr_mem_base = 12'h400; // program, write only

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_exec,
        st_halted
    } core_state_t;

endpackage

// ==== cpu/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; #(
    parameter  int MEM_DEPTH = 256,
    localparam int PC_W      = $clog2(MEM_DEPTH)
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 start,      // one cycle pulse from apb
    output logic [PC_W-1:0]      mem_raddr,
    input  logic [xlen-1:0]      mem_rdata,
    output logic                 busy,
    output logic                 halted,
    output logic [PC_W-1:0]      pc,
    input  logic [reg_idx_w-1:0] host_ridx,
    output logic [xlen-1:0]      host_rdata
);

    core_state_t          state;
    logic [xlen-1:0]      instr;
    logic [xlen-1:0]      pc_ext;
    logic [reg_idx_w-1:0] rs1_idx;
    logic [reg_idx_w-1:0] rs2_idx;
    logic [reg_idx_w-1:0] rd_idx;
    logic [xlen-1:0]      rs1_data;
    logic [xlen-1:0]      rs2_data;
    logic [xlen-1:0]      rd_data;
    logic [xlen-1:0]      next_pc;
    logic                 rd_we;
    logic                 is_halt;
    logic                 exec_en;

    // ------------------------------------------------------------------------
    // decode of register indices, word comes straight from the rom register
    // ------------------------------------------------------------------------
    assign instr   = mem_rdata;                     // valid in exec only
    assign rs1_idx = instr[rs1_lsb +: reg_idx_w];
    assign rs2_idx = instr[rs2_lsb +: reg_idx_w];
    assign rd_idx  = instr[rd_lsb +: reg_idx_w];
    assign pc_ext  = xlen'(pc);
    assign exec_en = state == st_exec;

    assign mem_raddr = pc;                          // fetch address, held in exec
    assign busy      = state == st_fetch || state == st_exec;
    assign halted    = state == st_halted;

    reg_file reg_file (
        .clk        (clk),
        .arst_n     (arst_n),
        .ra_idx     (rs1_idx),
        .rb_idx     (rs2_idx),
        .we         (exec_en & rd_we),              // commit on the exec edge
        .wa_idx     (rd_idx),
        .wdata      (rd_data),
        .host_ridx  (host_ridx),
        .ra_data    (rs1_data),
        .rb_data    (rs2_data),
        .host_rdata (host_rdata)
    );

    exec_unit exec_unit (
        .instr    (instr),
        .pc       (pc_ext),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rd_we    (rd_we),
        .rd_data  (rd_data),
        .next_pc  (next_pc),
        .is_halt  (is_halt)
    );

    // ------------------------------------------------------------------------
    // sequencer, two cycles per instruction
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            pc    <= '0;
        end else begin
            case (state)
                st_idle, st_halted: begin
                    if (start) begin                // restart always from word 0
                        state <= st_fetch;
                        pc    <= '0;
                    end
                end
                st_fetch: state <= st_exec;         // rom read in flight
                st_exec: begin
                    if (is_halt) begin
                        state <= st_halted;         // pc stays on the halt word
                    end else begin
                        state <= st_fetch;
                        pc    <= next_pc[PC_W-1:0]; // target wraps mod depth
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// ==== cpu/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit import cpu_pkg::*; (
    input  logic [xlen-1:0] instr,
    input  logic [xlen-1:0] pc,       // word address, zero extended
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    output logic            rd_we,
    output logic [xlen-1:0] rd_data,
    output logic [xlen-1:0] next_pc,  // caller wraps to mem depth
    output logic            is_halt
);

    logic [opcode_w-1:0]    opcode;
    logic [opt_w-1:0]       opt;
    logic signed [xlen-1:0] imm;      // sign extended
    logic signed [xlen-1:0] cmp;      // x[rs2] seen as signed
    logic [xlen-1:0]        pc_plus1;
    logic                   taken;

    assign opcode   = instr[opcode_lsb +: opcode_w];
    assign opt      = instr[opt_lsb +: opt_w];
    assign imm      = {{(xlen-imm_w){instr[imm_lsb+imm_w-1]}}, instr[imm_lsb +: imm_w]};
    assign cmp      = rs2_data;
    assign pc_plus1 = pc + 1'b1;

    always_comb begin
        case (opt)
            cond_eq: taken = cmp == 0;
            cond_ne: taken = cmp != 0;
            cond_ge: taken = cmp >= 0;
            cond_lt: taken = cmp < 0;
            cond_gt: taken = cmp > 0;
            cond_le: taken = cmp <= 0;
            default: taken = 1'b0;    // reserved opts never jump
        endcase
    end

    assign rd_we   = opcode == op_addi || opcode == op_jalr;
    assign rd_data = (opcode == op_jalr) ? pc_plus1 : rs1_data + imm; // link or sum
    assign next_pc = (opcode == op_jalr || (opcode == op_jcc && taken)) ? rs1_data : pc_plus1;
    assign is_halt = opcode == op_halt;

endmodule

// ==== cpu/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [reg_idx_w-1:0] ra_idx,     // rs1
    input  logic [reg_idx_w-1:0] rb_idx,     // rs2
    input  logic                 we,
    input  logic [reg_idx_w-1:0] wa_idx,     // rd
    input  logic [xlen-1:0]      wdata,
    input  logic [reg_idx_w-1:0] host_ridx,  // apb readback index
    output logic [xlen-1:0]      ra_data,
    output logic [xlen-1:0]      rb_data,
    output logic [xlen-1:0]      host_rdata
);

    logic [reg_count-1:0][xlen-1:0] x; // x[0] is never written

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x <= '0;
        end else if (we && wa_idx != '0) begin // writes to x0 dropped
            x[wa_idx] <= wdata;
        end
    end

    // combinational reads, same-cycle write not visible until next edge
    assign ra_data    = x[ra_idx];
    assign rb_data    = x[rb_idx];
    assign host_rdata = x[host_ridx];

endmodule

// ==== rtl/apb_regs.sv ====
`timescale 1ns/1ps

module apb_regs import cpu_pkg::*; #(
    parameter  int MEM_DEPTH = 256,
    localparam int PC_W      = $clog2(MEM_DEPTH)
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic [xlen-1:0]       pwdata,
    output logic [xlen-1:0]       prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  busy,
    input  logic                  halted,
    input  logic [PC_W-1:0]       pc,
    input  logic [xlen-1:0]       host_rdata,
    output logic                  mem_we,
    output logic [PC_W-1:0]       mem_waddr,
    output logic [xlen-1:0]       mem_wdata,
    output logic                  start,
    output logic [reg_idx_w-1:0]  host_ridx
);

    logic            access;       // apb access phase
    logic            hit_ctrl;
    logic            hit_status;
    logic            hit_reg;
    logic            hit_mem;      // inside the loaded depth
    logic            aligned;
    logic [7:0]      mem_word;     // word index in the 1 KiB program window
    logic [xlen-1:0] status_word;

    // ------------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------------
    assign access     = psel & penable;
    assign aligned    = paddr[1:0] == 2'b00;
    assign mem_word   = paddr[9:2];
    assign hit_ctrl   = paddr == addr_ctrl;
    assign hit_status = paddr == addr_status;
    assign hit_reg    = aligned && paddr[11:6] == addr_reg_base[11:6];   // 0x040..0x07f
    assign hit_mem    = aligned && paddr[11:10] == addr_mem_base[11:10]
                        && int'(mem_word) < MEM_DEPTH;

    // error on unmapped, write to read-only, read of write-only
    assign pslverr = access & (~(hit_ctrl | hit_status | hit_reg | hit_mem)
                              | (pwrite & (hit_status | hit_reg))
                              | (~pwrite & hit_mem));
    assign pready  = 1'b1;         // no wait states

    // program load, lands on the edge closing the access
    assign mem_we    = access & pwrite & hit_mem;
    assign mem_waddr = mem_word[PC_W-1:0];
    assign mem_wdata = pwdata;

    // start pulse, a write while running is dropped
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            start <= 1'b0;
        end else begin
            start <= access & pwrite & hit_ctrl & pwdata[0] & ~busy;
        end
    end

    // ------------------------------------------------------------------------
    // read mux, combinational from paddr
    // ------------------------------------------------------------------------
    assign host_ridx   = paddr[2 +: reg_idx_w];
    assign status_word = {16'(pc), 14'd0, halted, busy};

    always_comb begin
        prdata = '0;                                // ctrl and errors read 0
        if (hit_status) begin
            prdata = status_word;
        end else if (hit_reg) begin
            prdata = host_rdata;
        end
    end

endmodule

// ==== rtl/instr_mem.sv ====
`timescale 1ns/1ps

module instr_mem import cpu_pkg::*; #(
    parameter  int MEM_DEPTH = 256,
    localparam int PC_W      = $clog2(MEM_DEPTH)
) (
    input  logic            clk,
    input  logic            mem_we,    // host write strobe from apb
    input  logic [PC_W-1:0] mem_waddr,
    input  logic [xlen-1:0] mem_wdata,
    input  logic [PC_W-1:0] mem_raddr, // core fetch address
    output logic [xlen-1:0] mem_rdata  // valid one cycle after mem_raddr
);

    logic [xlen-1:0] mem [MEM_DEPTH]; // one instruction per word

    // host write port
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
    end

    // core read port, registered output
    // mem_raddr stays on pc through exec so the word is held there
    always_ff @(posedge clk) begin
        mem_rdata <= mem[mem_raddr];
    end

endmodule

// ==== rtl/mother_board.sv ====
`timescale 1ns/1ps

module mother_board import cpu_pkg::*; #(
    parameter int MEM_DEPTH = 256          // power of two, at most 256
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic [xlen-1:0]       pwdata,
    output logic [xlen-1:0]       prdata,
    output logic                  pready,
    output logic                  pslverr
);

    localparam int PC_W = $clog2(MEM_DEPTH);

    logic                 mem_we;
    logic [PC_W-1:0]      mem_waddr;
    logic [xlen-1:0]      mem_wdata;
    logic [PC_W-1:0]      mem_raddr;
    logic [xlen-1:0]      mem_rdata;
    logic                 start;
    logic                 busy;
    logic                 halted;
    logic [PC_W-1:0]      pc;
    logic [reg_idx_w-1:0] host_ridx;
    logic [xlen-1:0]      host_rdata;

    // host side
    apb_regs #(.MEM_DEPTH(MEM_DEPTH)) apb (
        .clk, .arst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .busy, .halted, .pc, .host_rdata,
        .mem_we, .mem_waddr, .mem_wdata,
        .start, .host_ridx
    );

    // program memory
    instr_mem #(.MEM_DEPTH(MEM_DEPTH)) rom (
        .clk, .mem_we, .mem_waddr, .mem_wdata,
        .mem_raddr, .mem_rdata
    );

    // core with its register file
    cpu_core #(.MEM_DEPTH(MEM_DEPTH)) cpu (
        .clk, .arst_n, .start,
        .mem_raddr, .mem_rdata,
        .busy, .halted, .pc,
        .host_ridx, .host_rdata
    );

endmodule

// ==== sources.f ====
common/cpu_pkg.sv
rtl/instr_mem.sv
cpu/reg_file.sv
cpu/exec_unit.sv
cpu/cpu_core.sv
rtl/apb_regs.sv
rtl/mother_board.sv
verif/tb_clock.sv
verif/cpu_assertions.sv
verif/tb_mother_board.sv

// ==== verif/cpu_assertions.sv ====
`timescale 1ns/1ps

module cpu_assertions import cpu_pkg::*; #(
    parameter  int MEM_DEPTH = 256,
    localparam int PC_W      = $clog2(MEM_DEPTH)
) (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 start,
    input core_state_t          state,
    input logic                 busy,
    input logic                 halted,
    input logic [PC_W-1:0]      pc,
    input logic [xlen-1:0]      next_pc,
    input logic                 is_halt,
    input logic [reg_idx_w-1:0] rs1_idx,
    input logic [reg_idx_w-1:0] rs2_idx,
    input logic [xlen-1:0]      rs1_data,
    input logic [xlen-1:0]      rs2_data
);

    logic [PC_W-1:0] next_pc_w;  // target as the sequencer sees it

    assign next_pc_w = next_pc[PC_W-1:0];

    // ------------------------------------------------------------------------
    // sequencer rules
    // ------------------------------------------------------------------------
    assert property (@(posedge clk) disable iff (!arst_n) !(busy && halted))
        else $error("busy and halted are high in the same cycle");

    // a start in flight must not restart the sequence
    assert property (@(posedge clk) disable iff (!arst_n)
        (start && state == st_fetch) |=> state == st_exec)
        else $error("start during fetch changed the sequence");

    assert property (@(posedge clk) disable iff (!arst_n)
        (start && state == st_exec && !is_halt) |=> (state == st_fetch && pc == $past(next_pc_w)))
        else $error("start during exec changed the sequence");

    assert property (@(posedge clk) disable iff (!arst_n) int'(pc) < MEM_DEPTH)
        else $error("pc outside program memory");

    // ------------------------------------------------------------------------
    // x0 reads back as zero on both decode ports
    // ------------------------------------------------------------------------
    assert property (@(posedge clk) disable iff (!arst_n) (rs1_idx == '0) |-> rs1_data == '0)
        else $error("x0 holds a nonzero value on rs1");

    assert property (@(posedge clk) disable iff (!arst_n) (rs2_idx == '0) |-> rs2_data == '0)
        else $error("x0 holds a nonzero value on rs2");

endmodule

bind cpu_core cpu_assertions #(.MEM_DEPTH(MEM_DEPTH)) cpu_checks (
    .clk      (clk),
    .arst_n   (arst_n),
    .start    (start),
    .state    (state),
    .busy     (busy),
    .halted   (halted),
    .pc       (pc),
    .next_pc  (next_pc),
    .is_halt  (is_halt),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
);

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 8.0   // 125 MHz
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk; // half period per phase
        end
    end

endmodule

// ==== verif/tb_mother_board.sv ====
`timescale 1ns/1ps

module tb_mother_board import cpu_pkg::*; ();

    localparam int MEM_DEPTH  = 256;
    localparam int max_steps  = 200;   // model gives up after this many instructions
    localparam int poll_limit = 500;   // status polls per run

    logic                  clk;
    logic                  arst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    logic [xlen-1:0]       pwdata;
    logic [xlen-1:0]       prdata;
    logic                  pready;
    logic                  pslverr;

    logic [xlen-1:0] prog [MEM_DEPTH];    // mirror of the program memory
    logic [xlen-1:0] img [MEM_DEPTH];     // next image, committed on load
    logic [xlen-1:0] model_x [reg_count]; // model registers, kept across runs
    int              model_pc;            // address of the halt

    tb_clock clock_gen (.clk(clk));

    mother_board #(.MEM_DEPTH(MEM_DEPTH)) uut (
        .clk, .arst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr
    );

    // ------------------------------------------------------------------------
    // checks and apb host
    // ------------------------------------------------------------------------
    task automatic check_equal(input logic [xlen-1:0] actual, input logic [xlen-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic fail_now(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping on error");
    endtask

    // setup then access, inputs change on the falling edge only
    task automatic apb_access(input logic write, input logic [apb_addr_w-1:0] addr,
                              input logic [xlen-1:0] wdata, output logic [xlen-1:0] rdata,
                              output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;                                 // mid access phase, outputs settled
        rdata = prdata;
        err   = pslverr;
        check_equal(32'(pready), 32'd1, "pready in access phase");
        @(negedge clk);                     // write landed on the rising edge
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [apb_addr_w-1:0] addr, input logic [xlen-1:0] data);
        logic [xlen-1:0] rdata;
        logic            err;
        apb_access(1'b1, addr, data, rdata, err);
        check_equal(32'(err), 32'd0, $sformatf("pslverr on write to %h", addr));
    endtask

    task automatic apb_read(input logic [apb_addr_w-1:0] addr, output logic [xlen-1:0] data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        check_equal(32'(err), 32'd0, $sformatf("pslverr on read of %h", addr));
    endtask

    task automatic read_reg(input int idx, output logic [xlen-1:0] data);
        apb_read(addr_reg_base + 12'(4 * idx), data);
    endtask

    task automatic wait_halted();
        logic [xlen-1:0] st;
        int              polls;
        for (polls = 0; polls < poll_limit; polls++) begin
            apb_read(addr_status, st);
            if (st[1]) begin
                return;
            end
        end
        fail_now("core did not halt within the poll limit");
    endtask

    // ------------------------------------------------------------------------
    // instruction model
    // ------------------------------------------------------------------------
    function automatic logic [xlen-1:0] encode(input logic [3:0] op, input logic [3:0] opt,
                                               input logic [3:0] rd, input logic [3:0] rs1,
                                               input logic [3:0] rs2, input logic [11:0] imm);
        return {imm, rs2, rs1, rd, opt, op};  // top bits down
    endfunction

    function automatic logic [3:0] random_index();
        return 4'($urandom);
    endfunction

    function automatic bit cond_taken(input logic [3:0] opt, input logic signed [xlen-1:0] v);
        case (opt)
            4'd0:    return v == 0;
            4'd1:    return v != 0;
            4'd2:    return v >= 0;
            4'd3:    return v < 0;
            4'd4:    return v > 0;
            4'd5:    return v <= 0;
            default: return 1'b0;             // 6..15 never jump
        endcase
    endfunction

    // runs img from word 0, commits registers only when it halts
    task automatic model_run(output bit done);
        logic [xlen-1:0]        xs [reg_count];
        logic [xlen-1:0]        instr;
        logic [xlen-1:0]        link;
        logic signed [xlen-1:0] imm;
        logic [3:0]             op;
        logic [3:0]             rd;
        logic [3:0]             rs1;
        logic [3:0]             rs2;
        int                     pc;
        int                     steps;
        xs   = model_x;
        pc   = 0;
        done = 1'b0;
        for (steps = 0; steps < max_steps && !done; steps++) begin
            instr = img[pc];
            op    = instr[3:0];
            rd    = instr[11:8];
            rs1   = instr[15:12];
            rs2   = instr[19:16];
            imm   = {{20{instr[31]}}, instr[31:20]};
            case (op)
                op_addi: begin
                    if (rd != 0) xs[rd] = xs[rs1] + imm;
                    pc = (pc + 1) % MEM_DEPTH;
                end
                op_jalr: begin
                    link = 32'(pc + 1);          // unwrapped pc+1
                    pc   = int'(xs[rs1] % 32'(MEM_DEPTH));
                    if (rd != 0) xs[rd] = link;
                end
                op_jcc: begin
                    if (cond_taken(instr[7:4], xs[rs2])) pc = int'(xs[rs1] % 32'(MEM_DEPTH));
                    else pc = (pc + 1) % MEM_DEPTH;
                end
                op_halt: done = 1'b1;
                default: pc = (pc + 1) % MEM_DEPTH;
            endcase
        end
        if (done) begin
            model_x  = xs;
            model_pc = pc;
        end
    endtask

    // ------------------------------------------------------------------------
    // program handling
    // ------------------------------------------------------------------------
    task automatic fill_memory();
        int a;
        for (a = 0; a < MEM_DEPTH; a++) begin
            prog[a] = encode(op_halt, 4'd0, a[3:0], a[7:4], 4'd0, 12'(a)); // halt tagged by addr
            apb_write(addr_mem_base + 12'(4 * a), prog[a]);
        end
    endtask

    task automatic gen_program(input bit mixed, input int len);
        int          i;
        int          sel;
        logic [11:0] imm;
        img = prog;
        for (i = 0; i < len - 1; i++) begin
            sel = mixed ? int'($urandom_range(0, 9)) : 0;
            imm = ($urandom_range(0, 1) == 1) ? 12'($urandom_range(0, 31)) : 12'($urandom);
            case (sel)
                5: img[i] = encode(op_jalr, 4'd0, random_index(), random_index(),
                                   random_index(), imm);
                6, 7: img[i] = encode(op_jcc, 4'($urandom_range(0, 7)), random_index(),
                                      random_index(), random_index(), imm);
                8, 9: img[i] = encode(4'($urandom_range(4, 9)), random_index(), random_index(),
                                      random_index(), random_index(), imm); // nop opcodes
                default: img[i] = encode(op_addi, random_index(), random_index(),
                                         random_index(), random_index(), imm);
            endcase
        end
        img[len - 1] = encode(op_halt, 4'd0, 4'd0, 4'd0, 4'd0, 12'd0);
    endtask

    task automatic load_program(input int len);
        int i;
        for (i = 0; i < len; i++) begin
            apb_write(addr_mem_base + 12'(4 * i), img[i]);
        end
        prog = img;
    endtask

    task automatic check_state();
        logic [xlen-1:0] val;
        int              i;
        apb_read(addr_status, val);
        check_equal(val, {16'(model_pc), 14'd0, 1'b1, 1'b0}, "status after halt");
        for (i = 0; i < reg_count; i++) begin
            read_reg(i, val);
            check_equal(val, model_x[i], $sformatf("register x%0d", i));
        end
    endtask

    task automatic load_and_run(input int len);
        load_program(len);
        apb_write(addr_ctrl, 32'd1);
        wait_halted();
        check_state();
    endtask

    task automatic random_run(input bit mixed);
        int tries;
        int len;
        bit done;
        done = 1'b0;
        for (tries = 0; tries < 100 && !done; tries++) begin
            len = $urandom_range(6, 20);
            gen_program(mixed, len);
            model_run(done);                  // looping programs get regenerated
        end
        if (!done) fail_now("no random program finished within the step limit");
        load_and_run(len);
    endtask

    // ------------------------------------------------------------------------
    // directed programs
    // ------------------------------------------------------------------------
    task automatic jalr_test();
        logic [xlen-1:0] old_x3;
        logic [xlen-1:0] val;
        bit              done;
        old_x3 = model_x[3];
        img    = prog;
        img[0] = encode(op_addi, 4'd0, 4'd1, 4'd0, 4'd0, 12'd4);     // x1 = 4
        img[1] = encode(op_jalr, 4'd0, 4'd2, 4'd1, 4'd0, 12'd0);     // x2 = 2, jump 4
        img[2] = encode(op_addi, 4'd0, 4'd3, 4'd0, 4'd0, 12'h111);   // skipped
        img[3] = encode(op_addi, 4'd0, 4'd3, 4'd0, 4'd0, 12'h222);   // skipped
        img[4] = encode(op_addi, 4'd0, 4'd4, 4'd2, 4'd0, 12'd5);     // x4 = x2 + 5
        img[5] = encode(op_halt, 4'd0, 4'd0, 4'd0, 4'd0, 12'd0);
        model_run(done);
        if (!done) fail_now("jalr program did not halt in the model");
        load_and_run(6);
        read_reg(2, val);
        check_equal(val, 32'd2, "jalr link register");
        read_reg(3, val);
        check_equal(val, old_x3, "register written by skipped code");
        read_reg(4, val);
        check_equal(val, 32'd7, "instruction at jump target");
    endtask

    task automatic cond_test(input logic [3:0] opt, input logic [11:0] v);
        logic [xlen-1:0] val;
        bit              taken;
        bit              done;
        taken  = cond_taken(opt, {{20{v[11]}}, v});
        img    = prog;
        img[0] = encode(op_addi, 4'd0, 4'd7, 4'd0, 4'd0, 12'd0);     // clear markers
        img[1] = encode(op_addi, 4'd0, 4'd8, 4'd0, 4'd0, 12'd0);
        img[2] = encode(op_addi, 4'd0, 4'd5, 4'd0, 4'd0, v);         // value under test
        img[3] = encode(op_addi, 4'd0, 4'd6, 4'd0, 4'd0, 12'd7);     // target
        img[4] = encode(op_jcc, opt, 4'd0, 4'd6, 4'd5, 12'd0);
        img[5] = encode(op_addi, 4'd0, 4'd7, 4'd0, 4'd0, 12'd1);     // fall through marker
        img[6] = encode(op_halt, 4'd0, 4'd0, 4'd0, 4'd0, 12'd0);
        img[7] = encode(op_addi, 4'd0, 4'd8, 4'd0, 4'd0, 12'd1);     // taken marker
        img[8] = encode(op_halt, 4'd0, 4'd0, 4'd0, 4'd0, 12'd0);
        model_run(done);
        if (!done) fail_now("condition program did not halt in the model");
        load_and_run(9);
        read_reg(7, val);
        check_equal(val, 32'(!taken), $sformatf("not-taken marker, opt %0d v %h", opt, v));
        read_reg(8, val);
        check_equal(val, 32'(taken), $sformatf("taken marker, opt %0d v %h", opt, v));
    endtask

    task automatic apb_error_test();
        logic [xlen-1:0] rdata;
        logic            err;
        apb_access(1'b0, 12'h008, '0, rdata, err);
        check_equal(32'(err), 32'd1, "pslverr on unmapped read");
        apb_access(1'b1, addr_status, 32'h5, rdata, err);
        check_equal(32'(err), 32'd1, "pslverr on status write");
        apb_access(1'b0, addr_mem_base, '0, rdata, err);
        check_equal(32'(err), 32'd1, "pslverr on program memory read");
        apb_access(1'b1, addr_reg_base + 12'h4, 32'h1, rdata, err);
        check_equal(32'(err), 32'd1, "pslverr on register write");
    endtask

    task automatic start_while_busy();
        logic [xlen-1:0] st;
        bit              done;
        gen_program(1'b0, 20);
        model_run(done);
        if (!done) fail_now("addi program did not halt in the model");
        load_program(20);
        apb_write(addr_ctrl, 32'd1);
        apb_read(addr_status, st);
        check_equal(32'(st[0]), 32'd1, "core busy after start");
        apb_write(addr_ctrl, 32'd1);        // second start, dropped by the slave
        wait_halted();
        check_state();
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [xlen-1:0] val;
        int              i;
        int              opt;
        void'($urandom(44));
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (i = 0; i < reg_count; i++) model_x[i] = '0;
        model_pc = 0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;

        apb_read(addr_status, val);
        check_equal(val, 32'd0, "status after reset");
        for (i = 0; i < reg_count; i++) begin
            read_reg(i, val);
            check_equal(val, 32'd0, $sformatf("x%0d after reset", i));
        end
        fill_memory();

        for (i = 0; i < 4; i++) random_run(1'b0);      // addi only
        jalr_test();
        for (opt = 0; opt < 16; opt++) begin
            cond_test(4'(opt), 12'hfff);              // -1
            cond_test(4'(opt), 12'h000);
            cond_test(4'(opt), 12'h001);
            cond_test(4'(opt), 12'($urandom));
        end
        for (i = 0; i < 20; i++) random_run(1'b1);     // mixed, back to back
        apb_error_test();
        start_while_busy();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
